/* logic/fetch_cfg_pkg.sv */
package fetch_cfg_pkg;

    // address and memory geometry
    localparam int ADDR_W     = 32;
    localparam int LINE_BYTES = 16;
    localparam int LINE_IDX_W = 28;

    // byte offset inside one line
    localparam int LINE_OFS_W = ADDR_W - LINE_IDX_W;

    // two lines side by side form the fetch window
    localparam int WIN_W = 2 * LINE_BYTES * 8;

    // one slot per halfword of a 16 byte block
    localparam int SLOTS  = 8;
    localparam int HALF_W = 16;

    // byte address
    typedef logic [ADDR_W-1:0] addr_t;

    // byte address without the line offset
    typedef logic [LINE_IDX_W-1:0] line_addr_t;

    // raw data of one cache line
    typedef logic [LINE_BYTES*8-1:0] line_t;

    // instruction text, compressed ones use the low half
    typedef logic [31:0] inst_t;

    // one bit per slot or per output lane
    typedef logic [SLOTS-1:0] slot_mask_t;

    // block size in bytes, 2 to 16
    typedef logic [4:0] blk_size_t;

endpackage

/* logic/branch_pkg.sv */
package branch_pkg;

    // control flow class of one instruction
    typedef enum logic [1:0] {
        BR_NONE     = 2'd0,
        BR_COND     = 2'd1,
        BR_DIRECT   = 2'd2,
        BR_INDIRECT = 2'd3
    } br_kind_e;

    // instruction lengths in bytes
    localparam int INST16_BYTES = 2;
    localparam int INST32_BYTES = 4;

    // base ISA major opcodes
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;

    // compressed forms, matched as {funct3, quadrant}
    localparam logic [4:0] CQ_J    = 5'b101_01;
    localparam logic [4:0] CQ_JAL  = 5'b001_01;
    localparam logic [4:0] CQ_BEQZ = 5'b110_01;
    localparam logic [4:0] CQ_BNEZ = 5'b111_01;

    // c.jr and c.jalr share this code, bit 12 tells them apart
    localparam logic [4:0] CQ_JR = 5'b100_10;

endpackage

/* logic/inst_predecoder.sv */
`timescale 1ns/10ps

module inst_predecoder
    import fetch_cfg_pkg::*;
    import branch_pkg::*;
(
    input  inst_t    i_inst,
    input  addr_t    i_pc,
    output logic     o_is32,
    output br_kind_e o_kind,
    output addr_t    o_target,
    output addr_t    o_fallthru
);

    logic [6:0] opcode;
    logic [4:0] c_code;
    logic       c_regs_ok;

    // sign extended branch offsets, one per encoding
    addr_t j_imm;
    addr_t b_imm;
    addr_t cj_imm;
    addr_t cb_imm;
    addr_t imm;

    assign o_is32 = (i_inst[1:0] == 2'b11);
    assign opcode = i_inst[6:0];
    assign c_code = {i_inst[15:13], i_inst[1:0]};

    // c.jr/c.jalr need rs1 set and rs2 clear, otherwise it is mv/add/ebreak
    assign c_regs_ok = (i_inst[6:2] == 5'd0) && (i_inst[11:7] != 5'd0);

    assign j_imm = {{12{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

    assign b_imm = {{20{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};

    // offset[11|4|9:8|10|6|7|3:1|5] lives in bits 12..2
    assign cj_imm = {{20{i_inst[12]}}, i_inst[12], i_inst[8], i_inst[10:9], i_inst[6],
                     i_inst[7], i_inst[2], i_inst[11], i_inst[5:3], 1'b0};

    // offset[8|4:3] in 12..10 and offset[7:6|2:1|5] in 6..2
    assign cb_imm = {{23{i_inst[12]}}, i_inst[12], i_inst[6:5], i_inst[2],
                     i_inst[11:10], i_inst[4:3], 1'b0};

    always_comb begin
        o_kind = BR_NONE;
        imm    = '0;
        if (o_is32) begin
            case (opcode)
                OP_JAL: begin
                    o_kind = BR_DIRECT;
                    imm    = j_imm;
                end
                OP_JALR: begin
                    o_kind = BR_INDIRECT;
                end
                OP_BRANCH: begin
                    o_kind = BR_COND;
                    imm    = b_imm;
                end
                default: ;
            endcase
        end else begin
            case (c_code)
                CQ_J, CQ_JAL: begin
                    o_kind = BR_DIRECT;
                    imm    = cj_imm;
                end
                CQ_BEQZ, CQ_BNEZ: begin
                    o_kind = BR_COND;
                    imm    = cb_imm;
                end
                CQ_JR: begin
                    if (c_regs_ok) begin
                        o_kind = BR_INDIRECT;
                    end
                end
                default: ;
            endcase
        end
    end

    // an indirect jump has no static target, it ends up at the pc itself
    assign o_target   = i_pc + imm;
    assign o_fallthru = i_pc + (o_is32 ? addr_t'(INST32_BYTES) : addr_t'(INST16_BYTES));

endmodule

/* logic/block_checker.sv */
`timescale 1ns/10ps

module block_checker
    import fetch_cfg_pkg::*;
    import branch_pkg::*;
(
    input  logic       i_vld,
    input  blk_size_t  i_size,
    input  addr_t      i_next,
    input  slot_mask_t i_is32,
    input  br_kind_e   i_kind     [SLOTS],
    input  addr_t      i_target   [SLOTS],
    input  addr_t      i_fallthru [SLOTS],
    output slot_mask_t o_slot_vld,
    output logic       o_mispred,
    output addr_t      o_fix_pc
);

    // slots that begin an instruction, and the ones that survive the cut
    slot_mask_t starts;
    slot_mask_t counted;
    logic [3:0] half;

    br_kind_e last_kind;
    addr_t    last_target;
    addr_t    last_fallthru;
    logic     pass;

    assign half = i_size[4:1];

    always_comb begin
        logic jump_seen;
        int   s;
        jump_seen = 1'b0;
        starts    = '0;
        counted   = '0;
        for (s = 0; s < SLOTS; s = s + 1) begin
            if (s == 0) begin
                starts[s] = 1'b1;
            end else begin
                // upper half of a 32-bit instruction is not a start
                starts[s] = !(starts[s-1] && i_is32[s-1]);
            end
            counted[s] = starts[s] && (s < half) && !jump_seen;
            if (counted[s] && (i_kind[s] == BR_DIRECT || i_kind[s] == BR_INDIRECT)) begin
                jump_seen = 1'b1;
            end
        end
    end

    // the youngest counted instruction decides where the block must go
    always_comb begin
        int s;
        last_kind     = i_kind[0];
        last_target   = i_target[0];
        last_fallthru = i_fallthru[0];
        for (s = 1; s < SLOTS; s = s + 1) begin
            if (counted[s]) begin
                last_kind     = i_kind[s];
                last_target   = i_target[s];
                last_fallthru = i_fallthru[s];
            end
        end
    end

    always_comb begin
        case (last_kind)
            BR_DIRECT:   pass = (last_target == i_next);
            BR_COND:     pass = (last_target == i_next) || (last_fallthru == i_next);
            BR_INDIRECT: pass = 1'b1;
            default:     pass = (last_fallthru == i_next);
        endcase
    end

    assign o_slot_vld = i_vld ? counted : '0;
    assign o_mispred  = i_vld && !pass;
    assign o_fix_pc   = (last_kind == BR_DIRECT) ? last_target : last_fallthru;

    // a size below 2 from the predictor would leave the block empty
    always_comb begin
        if (i_vld) begin
            assert final (o_slot_vld[0])
                else $error("block_checker: size %0d gives no valid slot", i_size);
        end
    end

endmodule

/* logic/entry_packer.sv */
`timescale 1ns/10ps

module entry_packer
    import fetch_cfg_pkg::*;
(
    input  slot_mask_t i_slot_vld,
    input  inst_t      i_slot_inst [SLOTS],
    input  addr_t      i_start,
    output slot_mask_t o_lane_vld,
    output inst_t      o_lane_inst [SLOTS],
    output addr_t      o_lane_pc   [SLOTS]
);

    always_comb begin
        int s;
        int l;
        int k;
        o_lane_vld = '0;
        for (l = 0; l < SLOTS; l = l + 1) begin
            o_lane_inst[l] = '0;
            o_lane_pc[l]   = i_start;
        end

        // k counts the valid slots seen so far and names the next free lane
        k = 0;
        for (s = 0; s < SLOTS; s = s + 1) begin
            if (i_slot_vld[s]) begin
                o_lane_vld[k]  = 1'b1;
                o_lane_inst[k] = i_slot_inst[s];
                o_lane_pc[k]   = i_start + (addr_t'(s) << 1);
                k = k + 1;
            end
        end
    end

    // lanes fill from 0 upward, so the mask plus one shares no bit with it
    always_comb begin
        assert final ((o_lane_vld & slot_mask_t'(o_lane_vld + 1'b1)) == '0)
            else $error("entry_packer: gap in lane mask %b", o_lane_vld);
    end

endmodule

/* logic/fetch_unit.sv */
`timescale 1ns/10ps

module fetch_unit
    import fetch_cfg_pkg::*;
    import branch_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    // fetch blocks from the predictor
    input  logic       i_blk_vld,
    input  addr_t      i_blk_start,
    input  addr_t      i_blk_next,
    input  blk_size_t  i_blk_size,
    output logic       o_blk_rdy,

    // instruction memory
    output logic       o_mem_req,
    output line_addr_t o_mem_addr,
    input  logic       i_mem_gnt,
    input  line_t      i_mem_line0,
    input  line_t      i_mem_line1,

    input  logic       i_stall,
    input  logic       i_flush,

    // packed entries towards decode
    output slot_mask_t o_entry_vld,
    output inst_t      o_entry_inst [SLOTS],
    output addr_t      o_entry_pc   [SLOTS],
    output slot_mask_t o_entry_exc,
    output logic       o_redirect,
    output addr_t      o_redirect_pc
);

    logic accept;

    // stage 1, block waiting for its memory lines
    logic      s1_vld;
    logic      s1_mis;
    addr_t     s1_start;
    addr_t     s1_next;
    blk_size_t s1_size;

    logic [WIN_W-1:0] window;
    inst_t            slot_inst     [SLOTS];
    addr_t            slot_pc       [SLOTS];
    slot_mask_t       slot_is32;
    br_kind_e         slot_kind     [SLOTS];
    addr_t            slot_target   [SLOTS];
    addr_t            slot_fallthru [SLOTS];

    slot_mask_t slot_vld;
    logic       mispred;
    addr_t      fix_pc;
    slot_mask_t lane_vld;
    inst_t      lane_inst [SLOTS];
    addr_t      lane_pc   [SLOTS];

    // output register
    slot_mask_t out_vld;
    slot_mask_t out_exc;
    inst_t      out_inst [SLOTS];
    addr_t      out_pc   [SLOTS];
    logic       out_mispred;
    addr_t      out_fix_pc;

    logic redirect_fire;
    logic take_s1;

    // odd blocks skip memory and go straight through
    assign o_blk_rdy  = !i_stall && (i_blk_start[0] || i_mem_gnt);
    assign o_mem_req  = i_blk_vld && !i_stall && !i_blk_start[0];
    assign o_mem_addr = i_blk_start[ADDR_W-1:LINE_OFS_W];
    assign accept     = i_blk_vld && o_blk_rdy;

    always_ff @(posedge clk) begin
        if (rst || i_flush) begin
            s1_vld <= 1'b0;
        end else if (!i_stall) begin
            s1_vld <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            s1_start <= i_blk_start;
            s1_next  <= i_blk_next;
            s1_size  <= i_blk_size;
            s1_mis   <= i_blk_start[0];
        end
    end

    // line pair shifted so that the block start sits at bit 0
    assign window = {i_mem_line1, i_mem_line0} >> {s1_start[LINE_OFS_W-1:0], 3'b000};

    for (genvar g = 0; g < SLOTS; g++) begin : gen_slot
        assign slot_inst[g] = window[HALF_W*g +: 32];
        assign slot_pc[g]   = s1_start + addr_t'(g * INST16_BYTES);

        inst_predecoder u_predec (
            .i_inst     (slot_inst[g]),
            .i_pc       (slot_pc[g]),
            .o_is32     (slot_is32[g]),
            .o_kind     (slot_kind[g]),
            .o_target   (slot_target[g]),
            .o_fallthru (slot_fallthru[g])
        );
    end

    block_checker u_checker (
        .i_vld      (s1_vld && !s1_mis),
        .i_size     (s1_size),
        .i_next     (s1_next),
        .i_is32     (slot_is32),
        .i_kind     (slot_kind),
        .i_target   (slot_target),
        .i_fallthru (slot_fallthru),
        .o_slot_vld (slot_vld),
        .o_mispred  (mispred),
        .o_fix_pc   (fix_pc)
    );

    entry_packer u_packer (
        .i_slot_vld  (slot_vld),
        .i_slot_inst (slot_inst),
        .i_start     (s1_start),
        .o_lane_vld  (lane_vld),
        .o_lane_inst (lane_inst),
        .o_lane_pc   (lane_pc)
    );

    // the redirect leaves with the entries, and the younger s1 block dies with it
    assign redirect_fire = out_mispred && !i_stall;
    assign take_s1       = s1_vld && !redirect_fire;

    always_ff @(posedge clk) begin
        if (rst || i_flush) begin
            out_vld     <= '0;
            out_exc     <= '0;
            out_mispred <= 1'b0;
        end else if (!i_stall) begin
            if (take_s1) begin
                out_vld     <= s1_mis ? slot_mask_t'(1) : lane_vld;
                out_exc     <= s1_mis ? slot_mask_t'(1) : '0;
                out_mispred <= mispred;
            end else begin
                out_vld     <= '0;
                out_exc     <= '0;
                out_mispred <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!i_stall) begin
            out_inst   <= lane_inst;
            out_pc     <= lane_pc;
            out_fix_pc <= fix_pc;
            // misaligned entry reports the faulting start pc
            if (s1_mis) begin
                out_pc[0] <= s1_start;
            end
        end
    end

    assign o_entry_vld   = out_vld;
    assign o_entry_exc   = out_exc;
    assign o_entry_inst  = out_inst;
    assign o_entry_pc    = out_pc;
    assign o_redirect    = redirect_fire;
    assign o_redirect_pc = out_fix_pc;

    assert property (@(posedge clk) disable iff (rst) i_stall |-> !o_mem_req)
        else $error("fetch_unit: memory request while stalled");

endmodule

/* verification/fetch_clk_gen.sv */
`timescale 1ns/10ps

module fetch_clk_gen #(
    parameter int PERIOD_NS = 100
) (
    output logic o_clk
);

    // free running, first rising edge after half a period
    initial begin
        o_clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) o_clk = ~o_clk;
        end
    end

endmodule

/* verification/tb_fetch_unit.sv */
`timescale 1ns/10ps

module tb_fetch_unit
    import fetch_cfg_pkg::*;
    import branch_pkg::*;
();

    localparam int CLK_PERIOD = 100;
    localparam int LEN_SHORT  = 300;
    localparam int LEN_STD    = 400;
    localparam int LEN_LONG   = 600;
    localparam int LEN_DRAIN  = 30;
    localparam int RUN_CYCLES = 2 + 4 * LEN_STD + LEN_SHORT + LEN_LONG + LEN_DRAIN;

    typedef struct packed {
        addr_t     start;
        addr_t     next;
        blk_size_t size;
    } blk_t;

    logic       clk;
    logic       rst;
    logic       blk_vld;
    addr_t      blk_start;
    addr_t      blk_next;
    blk_size_t  blk_size;
    logic       blk_rdy;
    logic       mem_req;
    line_addr_t mem_addr;
    logic       mem_gnt;
    line_t      mem_line0;
    line_t      mem_line1;
    logic       stall;
    logic       flush;
    slot_mask_t entry_vld;
    inst_t      entry_inst [SLOTS];
    addr_t      entry_pc   [SLOTS];
    slot_mask_t entry_exc;
    logic       redirect;
    addr_t      redirect_pc;

    // memory image, 64 lines
    line_t mem_tbl [64];

    // model state, blocks in s1 and the expected output register
    blk_t       inflight [$];
    slot_mask_t exp_vld;
    slot_mask_t exp_exc;
    inst_t      exp_inst [SLOTS];
    addr_t      exp_pc   [SLOTS];
    logic       exp_mispred;
    addr_t      exp_fix;

    // result of the last block analysis
    slot_mask_t an_vld;
    inst_t      an_inst [SLOTS];
    addr_t      an_pc   [SLOTS];
    br_kind_e   an_kind;
    addr_t      an_tgt;
    addr_t      an_ft;
    logic       an_cross;

    int errors;
    int checks;
    int total_out;
    int ph_out;
    int ph_redir;
    int ph_drop;
    int ph_stall;
    int ph_flush;
    int ph_cross;
    int ph_odd;

    fetch_clk_gen #(.PERIOD_NS(CLK_PERIOD)) clk_gen_i (.o_clk(clk));

    fetch_unit fetch_unit_i (
        .clk           (clk),
        .rst           (rst),
        .i_blk_vld     (blk_vld),
        .i_blk_start   (blk_start),
        .i_blk_next    (blk_next),
        .i_blk_size    (blk_size),
        .o_blk_rdy     (blk_rdy),
        .o_mem_req     (mem_req),
        .o_mem_addr    (mem_addr),
        .i_mem_gnt     (mem_gnt),
        .i_mem_line0   (mem_line0),
        .i_mem_line1   (mem_line1),
        .i_stall       (stall),
        .i_flush       (flush),
        .o_entry_vld   (entry_vld),
        .o_entry_inst  (entry_inst),
        .o_entry_pc    (entry_pc),
        .o_entry_exc   (entry_exc),
        .o_redirect    (redirect),
        .o_redirect_pc (redirect_pc)
    );

    task automatic report_fail(input string msg);
        $display("[FAIL] t=%0d ns: %s", $time, msg);
        errors++;
    endtask

    task automatic fill_memory();
        int r;
        int w;
        int h;
        for (r = 0; r < 64; r++) begin
            for (w = 0; w < 4; w++) begin
                mem_tbl[r][32*w +: 32] = $urandom;
            end
            // one planted control transfer per line so that blocks end early now and then
            h = $urandom_range(7, 0);
            case ($urandom_range(3, 0))
                0: mem_tbl[r][16*h +: 7] = 7'b1101111;
                1: mem_tbl[r][16*h +: 7] = 7'b1100011;
                2: mem_tbl[r][16*h +: 7] = 7'b1100111;
                default: begin
                    mem_tbl[r][16*h +: 2]    = 2'b01;
                    mem_tbl[r][16*h+13 +: 3] = 3'b101;
                end
            endcase
        end
    endtask

    // byte k of the block, counted from its start inside the two line window
    function automatic logic [7:0] mem_byte(input addr_t start, input int k);
        int         b;
        logic [5:0] row;
        b   = int'(start[3:0]) + k;
        row = start[9:4];
        if (b >= 32) begin
            return 8'h00;
        end
        if (b >= 16) begin
            row = row + 6'd1;
            b   = b - 16;
        end
        return mem_tbl[row][8*b +: 8];
    endfunction

    function automatic inst_t slot_text(input addr_t start, input int s);
        inst_t t;
        int    k;
        for (k = 0; k < 4; k++) begin
            t[8*k +: 8] = mem_byte(start, 2 * s + k);
        end
        return t;
    endfunction

    task automatic predecode(input inst_t t, input addr_t pc, output logic is32,
                             output br_kind_e kind, output addr_t tgt, output addr_t ft);
        logic [31:0] off;
        off  = '0;
        kind = BR_NONE;
        is32 = (t[1:0] == 2'b11);
        if (is32 && t[6:0] == 7'b1101111) begin
            kind       = BR_DIRECT;
            off[20]    = t[31];
            off[19:12] = t[19:12];
            off[11]    = t[20];
            off[10:1]  = t[30:21];
            off        = {{11{off[20]}}, off[20:0]};
        end else if (is32 && t[6:0] == 7'b1100011) begin
            kind      = BR_COND;
            off[12]   = t[31];
            off[11]   = t[7];
            off[10:5] = t[30:25];
            off[4:1]  = t[11:8];
            off       = {{19{off[12]}}, off[12:0]};
        end else if (is32 && t[6:0] == 7'b1100111) begin
            kind = BR_INDIRECT;
        end else if (!is32 && t[1:0] == 2'b01 && t[14:13] == 2'b01) begin
            // c.j and c.jal
            kind     = BR_DIRECT;
            off[11]  = t[12];
            off[10]  = t[8];
            off[9:8] = t[10:9];
            off[7]   = t[6];
            off[6]   = t[7];
            off[5]   = t[2];
            off[4]   = t[11];
            off[3:1] = t[5:3];
            off      = {{20{off[11]}}, off[11:0]};
        end else if (!is32 && t[1:0] == 2'b01 && t[15:14] == 2'b11) begin
            // c.beqz and c.bnez
            kind     = BR_COND;
            off[8]   = t[12];
            off[7:6] = t[6:5];
            off[5]   = t[2];
            off[4:3] = t[11:10];
            off[2:1] = t[4:3];
            off      = {{23{off[8]}}, off[8:0]};
        end else if (!is32 && t[1:0] == 2'b10 && t[15:13] == 3'b100) begin
            if (t[6:2] == 5'd0 && t[11:7] != 5'd0) begin
                kind = BR_INDIRECT;
            end
        end
        tgt = pc + off;
        ft  = pc + (is32 ? 32'd4 : 32'd2);
    endtask

    // boundaries, valid slots and packing of one aligned block
    task automatic analyze_block(input addr_t start, input blk_size_t size);
        int       s;
        int       k;
        logic     cur_start;
        logic     prev_start;
        logic     prev32;
        logic     jumped;
        logic     is32;
        br_kind_e kind;
        addr_t    tgt;
        addr_t    ft;
        inst_t    t;
        k          = 0;
        prev_start = 1'b0;
        prev32     = 1'b0;
        jumped     = 1'b0;
        an_vld     = '0;
        an_cross   = 1'b0;
        for (s = 0; s < SLOTS; s++) begin
            t = slot_text(start, s);
            predecode(t, start + 2 * s, is32, kind, tgt, ft);
            cur_start = (s == 0) || !(prev_start && prev32);
            if (cur_start && s < int'(size) / 2 && !jumped) begin
                an_vld[k]  = 1'b1;
                an_inst[k] = t;
                an_pc[k]   = start + 2 * s;
                an_kind    = kind;
                an_tgt     = tgt;
                an_ft      = ft;
                k++;
                jumped = (kind == BR_DIRECT) || (kind == BR_INDIRECT);
                if (is32 && int'(start[3:0]) + 2 * s == 14) begin
                    an_cross = 1'b1;
                end
            end
            prev_start = cur_start;
            prev32     = is32;
        end
    endtask

    function automatic logic next_ok(input addr_t nxt);
        case (an_kind)
            BR_DIRECT:   return nxt == an_tgt;
            BR_COND:     return (nxt == an_tgt) || (nxt == an_ft);
            BR_INDIRECT: return 1'b1;
            default:     return nxt == an_ft;
        endcase
    endfunction

    task automatic clear_expect();
        exp_vld     = '0;
        exp_exc     = '0;
        exp_mispred = 1'b0;
    endtask

    task automatic expect_block(input blk_t b);
        if (b.start[0]) begin
            exp_vld     = 8'h01;
            exp_exc     = 8'h01;
            exp_pc[0]   = b.start;
            exp_mispred = 1'b0;
            ph_odd++;
        end else begin
            analyze_block(b.start, b.size);
            exp_vld     = an_vld;
            exp_exc     = '0;
            exp_inst    = an_inst;
            exp_pc      = an_pc;
            exp_mispred = !next_ok(b.next);
            exp_fix     = (an_kind == BR_DIRECT) ? an_tgt : an_ft;
            if (an_cross) begin
                ph_cross++;
            end
        end
    endtask

    // one clock edge of the model: s1 moves to the output, a new block enters s1
    task automatic advance_model(input logic acc, input logic redir, input blk_t b);
        blk_t head;
        if (flush) begin
            ph_drop += inflight.size() + (acc ? 1 : 0);
            inflight.delete();
            clear_expect();
        end else if (!stall) begin
            if (inflight.size() > 0 && !redir) begin
                head = inflight.pop_front();
                expect_block(head);
                ph_out++;
                total_out++;
            end else begin
                if (inflight.size() > 0) begin
                    head = inflight.pop_front();
                    ph_drop++;
                end
                clear_expect();
            end
            if (acc) begin
                inflight.push_back(b);
            end
        end
    endtask

    task automatic compare_outputs();
        int l;
        checks++;
        if (entry_vld !== exp_vld) begin
            report_fail($sformatf("entry valid %b, expected %b", entry_vld, exp_vld));
        end
        if (entry_exc !== exp_exc) begin
            report_fail($sformatf("entry exception %b, expected %b", entry_exc, exp_exc));
        end
        for (l = 0; l < SLOTS; l++) begin
            if (exp_vld[l] && entry_pc[l] !== exp_pc[l]) begin
                report_fail($sformatf("lane %0d pc %h, expected %h", l, entry_pc[l], exp_pc[l]));
            end
            if (exp_vld[l] && !exp_exc[l] && entry_inst[l] !== exp_inst[l]) begin
                report_fail($sformatf("lane %0d text %h, expected %h", l, entry_inst[l],
                                      exp_inst[l]));
            end
        end
        if (redirect !== (exp_mispred && !stall)) begin
            report_fail($sformatf("redirect %b, expected %b", redirect, exp_mispred && !stall));
        end else if (redirect && redirect_pc !== exp_fix) begin
            report_fail($sformatf("redirect pc %h, expected %h", redirect_pc, exp_fix));
        end
    endtask

    task automatic offer_block(input int p_odd, input int p_bad, input int p_late);
        addr_t     st;
        addr_t     nx;
        blk_size_t sz;
        st    = $urandom;
        st[0] = ($urandom_range(99, 0) < p_odd);
        // start in the last halfword so that a 32-bit instruction crosses the line
        if ($urandom_range(99, 0) < p_late) begin
            st[3:1] = 3'b111;
        end
        sz = blk_size_t'(2 * $urandom_range(8, 1));
        analyze_block(st, sz);
        case (an_kind)
            BR_DIRECT:   nx = an_tgt;
            BR_COND:     nx = $urandom_range(1, 0) ? an_tgt : an_ft;
            BR_INDIRECT: nx = $urandom;
            default:     nx = an_ft;
        endcase
        if ($urandom_range(99, 0) < p_bad) begin
            nx = $urandom;
        end
        blk_vld   <= 1'b1;
        blk_start <= st;
        blk_next  <= nx;
        blk_size  <= sz;
    endtask

    task automatic run_phase(input string name, input int cycles, input int p_offer,
                             input int p_odd, input int p_bad, input int p_late,
                             input int p_stall, input int p_flush);
        int    c;
        int    err0;
        logic  m_req;
        logic  m_rdy;
        logic  m_acc;
        logic  m_redir;
        blk_t  b;
        string msg;
        err0     = errors;
        ph_out   = 0;
        ph_redir = 0;
        ph_drop  = 0;
        ph_stall = 0;
        ph_flush = 0;
        ph_cross = 0;
        ph_odd   = 0;
        for (c = 0; c < cycles; c++) begin
            @(negedge clk);
            compare_outputs();
            m_req   = blk_vld && !stall && !blk_start[0];
            m_rdy   = !stall && (blk_start[0] || mem_gnt);
            m_acc   = blk_vld && m_rdy;
            m_redir = exp_mispred && !stall;
            if (mem_req !== m_req) begin
                report_fail($sformatf("memory request %b, expected %b", mem_req, m_req));
            end
            if (blk_rdy !== m_rdy) begin
                report_fail($sformatf("block ready %b, expected %b", blk_rdy, m_rdy));
            end
            if (m_req && mem_addr !== blk_start[31:4]) begin
                report_fail($sformatf("line address %h, expected %h", mem_addr, blk_start[31:4]));
            end
            ph_redir += m_redir ? 1 : 0;
            ph_stall += stall ? 1 : 0;
            ph_flush += flush ? 1 : 0;

            @(posedge clk);
            b.start = blk_start;
            b.next  = blk_next;
            b.size  = blk_size;
            advance_model(m_acc, m_redir, b);
            // memory answers the cycle after a grant and holds until the next one
            if (m_req && mem_gnt) begin
                mem_line0 <= mem_tbl[blk_start[9:4]];
                mem_line1 <= mem_tbl[blk_start[9:4] + 6'd1];
            end
            stall   <= ($urandom_range(99, 0) < p_stall);
            flush   <= ($urandom_range(99, 0) < p_flush);
            mem_gnt <= ($urandom_range(99, 0) < 70);
            if (m_acc || !blk_vld) begin
                if ($urandom_range(99, 0) < p_offer) begin
                    offer_block(p_odd, p_bad, p_late);
                end else begin
                    blk_vld <= 1'b0;
                end
            end
        end
        msg = $sformatf("%s: %0d cycles, %0d blocks out, %0d redirects, %0d dropped,",
                        name, cycles, ph_out, ph_redir, ph_drop);
        msg = {msg, $sformatf(" %0d odd, %0d crossing, %0d stall, %0d flush, %0d errors",
                              ph_odd, ph_cross, ph_stall, ph_flush, errors - err0)};
        $display("%s", msg);
    endtask

    initial begin
        #((RUN_CYCLES + 200) * CLK_PERIOD);
        $display("watchdog: run did not end within %0d cycles", RUN_CYCLES + 200);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int seed_ret;
        seed_ret  = $urandom(68);
        errors    = 0;
        checks    = 0;
        total_out = 0;
        fill_memory();
        clear_expect();
        exp_fix   = '0;
        rst       <= 1'b1;
        blk_vld   <= 1'b0;
        blk_start <= '0;
        blk_next  <= '0;
        blk_size  <= 5'd2;
        mem_gnt   <= 1'b0;
        mem_line0 <= '0;
        mem_line1 <= '0;
        stall     <= 1'b0;
        flush     <= 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        //        name        cycles     offer odd bad late stall flush
        run_phase("aligned",  LEN_STD,   85,   0,  0,  0,   0,    0);
        run_phase("mixed",    LEN_STD,   85,   0,  0,  60,  0,    0);
        run_phase("redirect", LEN_STD,   90,   0,  40, 20,  0,    0);
        run_phase("odd",      LEN_SHORT, 85,   50, 10, 0,   0,    0);
        run_phase("stall",    LEN_LONG,  85,   10, 15, 20,  25,   0);
        run_phase("flush",    LEN_STD,   85,   10, 15, 20,  10,   6);
        run_phase("drain",    LEN_DRAIN, 0,    0,  0,  0,   0,    0);

        $display("summary: %0d checks, %0d blocks out, %0d errors", checks, total_out, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* project.f */
logic/fetch_cfg_pkg.sv
logic/branch_pkg.sv
logic/inst_predecoder.sv
logic/block_checker.sv
logic/entry_packer.sv
logic/fetch_unit.sv
verification/fetch_clk_gen.sv
verification/tb_fetch_unit.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it, then scan the log
verilator --binary --timing --assert -Wno-fatal --top-module tb_fetch_unit \
    -f project.f -o tb_fetch_unit > build.log 2>&1 \
    && ./obj_dir/tb_fetch_unit > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0
